// File: logic/csr_bridge_macros.svh
`ifndef CSR_BRIDGE_MACROS_SVH
`define CSR_BRIDGE_MACROS_SVH

// ----------------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------------

`define CSR_AXI_ADDR_W    21                  // Host byte address
`define CSR_DATA_W        32
`define CSR_STRB_W        (`CSR_DATA_W / 8)   // One strobe per byte lane

// Register space is addressed by the low host address bits
`define CSR_ADDR_W        16

`define CSR_ID_W          4                   // AXI transaction ID

// ----------------------------------------------------------------------------
// Mailbox register map
// ----------------------------------------------------------------------------

// Command word written by the host
`define CSR_MBX_CMD_ADDR  16'h0150

// Counts accepted command and data writes, read only
`define CSR_DOORBELL_ADDR 16'h0154

`define CSR_MBX_DATA_ADDR 16'h0158            // Top of the mapped window

`endif

// File: logic/csr_bridge_pkg.sv
`include "csr_bridge_macros.svh"

package csr_bridge_pkg;

   // -------------------------------------------------------------------------
   // Payload types
   // -------------------------------------------------------------------------

   typedef logic [`CSR_AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [`CSR_ADDR_W-1:0]     csr_addr_t;   // Register offset
   typedef logic [`CSR_DATA_W-1:0]     csr_data_t;
   typedef logic [`CSR_STRB_W-1:0]     csr_strb_t;
   typedef logic [`CSR_ID_W-1:0]       axi_id_t;

   // -------------------------------------------------------------------------
   // Engine states
   // -------------------------------------------------------------------------

   // Write side
   typedef enum logic [2:0] {
      WR_IDLE      = 3'b000,
      WR_ADDR_RDY  = 3'b001,   // awready pulse
      WR_DATA_WAIT = 3'b010,
      WR_DATA_RDY  = 3'b011,   // wready and register write
      WR_BRESP     = 3'b100    // Holding bvalid
   } wr_state_t;

   // Read side
   typedef enum logic [2:0] {
      RD_IDLE      = 3'b000,
      RD_ADDR_RDY  = 3'b001,   // arready pulse
      RD_REG_RD    = 3'b010,   // Register read strobe
      RD_DATA_WAIT = 3'b011,
      RD_RRDY_WAIT = 3'b100    // Holding rvalid
   } rd_state_t;

endpackage

// File: logic/axi_write_slave.sv
`timescale 1ns/1ps
`include "csr_bridge_macros.svh"

module axi_write_slave (
   input  logic                      clk,
   input  logic                      rst_n,
   // Write address channel
   input  logic                      awvalid,
   input  csr_bridge_pkg::axi_addr_t awaddr,
   input  csr_bridge_pkg::axi_id_t   awid,
   output logic                      awready,
   // Write data channel
   input  logic                      wvalid,
   input  csr_bridge_pkg::csr_data_t wdata,
   input  csr_bridge_pkg::csr_strb_t wstrb,
   output logic                      wready,
   // Write response channel
   input  logic                      bready,
   output logic                      bvalid,
   output csr_bridge_pkg::axi_id_t   bid,
   // Register write port
   output logic                      reg_wen,
   output csr_bridge_pkg::csr_addr_t reg_waddr,
   output csr_bridge_pkg::csr_data_t reg_wdata,
   output csr_bridge_pkg::csr_strb_t reg_wstrb
);

   import csr_bridge_pkg::*;

   logic      awvalid_q;
   logic      wvalid_q;
   axi_addr_t awaddr_q;
   axi_id_t   awid_q;
   csr_data_t wdata_q;
   csr_strb_t wstrb_q;

   csr_addr_t waddr_lat;   // Held from the address handshake
   axi_id_t   awid_lat;

   wr_state_t wr_state;
   wr_state_t wr_next;

   // -------------------------------------------------------------------------
   // Host input sampling
   // -------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         awvalid_q <= 1'b0;
         wvalid_q  <= 1'b0;
      end
      else
      begin
         awvalid_q <= awvalid;
         wvalid_q  <= wvalid;
      end
   end

   always_ff @(posedge clk)
   begin
      awaddr_q <= awaddr;
      awid_q   <= awid;
      wdata_q  <= wdata;
      wstrb_q  <= wstrb;
   end

   // -------------------------------------------------------------------------
   // Write engine
   // -------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         wr_state <= WR_IDLE;
      else
         wr_state <= wr_next;
   end

   always_comb
   begin
      wr_next = wr_state;
      case (wr_state)
         WR_IDLE      : if (awvalid_q) wr_next = WR_ADDR_RDY;
         WR_ADDR_RDY  : wr_next = WR_DATA_WAIT;
         WR_DATA_WAIT : if (wvalid_q) wr_next = WR_DATA_RDY;
         WR_DATA_RDY  : wr_next = WR_BRESP;
         WR_BRESP     : if (bready) wr_next = WR_IDLE;   // Stall until host takes it
         default      : wr_next = WR_IDLE;
      endcase
   end

   // Address and ID taken on the handshake cycle
   always_ff @(posedge clk)
   begin
      if (awvalid_q && awready)
      begin
         waddr_lat <= awaddr_q[`CSR_ADDR_W-1:0];
         awid_lat  <= awid_q;
      end
   end

   // Ready, valid and enable pulses follow the next state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         reg_wen <= 1'b0;
      end
      else
      begin
         awready <= (wr_next == WR_ADDR_RDY);
         wready  <= (wr_next == WR_DATA_RDY);
         reg_wen <= (wr_next == WR_DATA_RDY);   // Same cycle as wready
         bvalid  <= (wr_next == WR_BRESP);
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_next == WR_DATA_RDY)
      begin
         reg_waddr <= waddr_lat;
         reg_wdata <= wdata_q;
         reg_wstrb <= wstrb_q;
      end
      // ID stays put for the whole response
      if (wr_state == WR_DATA_RDY)
         bid <= awid_lat;
   end

endmodule

// File: logic/axi_read_slave.sv
`timescale 1ns/1ps
`include "csr_bridge_macros.svh"

module axi_read_slave (
   input  logic                      clk,
   input  logic                      rst_n,
   // Read address channel
   input  logic                      arvalid,
   input  csr_bridge_pkg::axi_addr_t araddr,
   input  csr_bridge_pkg::axi_id_t   arid,
   output logic                      arready,
   // Read data channel
   input  logic                      rready,
   output logic                      rvalid,
   output csr_bridge_pkg::csr_data_t rdata,
   output csr_bridge_pkg::axi_id_t   rid,
   // Register read port
   output logic                      reg_ren,
   output csr_bridge_pkg::csr_addr_t reg_raddr,
   input  csr_bridge_pkg::csr_data_t reg_rdata
);

   import csr_bridge_pkg::*;

   logic      arvalid_q;
   axi_addr_t araddr_q;
   axi_id_t   arid_q;
   axi_id_t   arid_lat;

   rd_state_t rd_state;
   rd_state_t rd_next;

   // -------------------------------------------------------------------------
   // Host input sampling
   // -------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         arvalid_q <= 1'b0;
      else
         arvalid_q <= arvalid;
   end

   always_ff @(posedge clk)
   begin
      araddr_q <= araddr;
      arid_q   <= arid;
   end

   // -------------------------------------------------------------------------
   // Read engine
   // -------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rd_state <= RD_IDLE;
      else
         rd_state <= rd_next;
   end

   always_comb
   begin
      rd_next = rd_state;
      case (rd_state)
         RD_IDLE      : if (arvalid_q) rd_next = RD_ADDR_RDY;
         RD_ADDR_RDY  : rd_next = RD_REG_RD;
         RD_REG_RD    : rd_next = RD_DATA_WAIT;
         RD_DATA_WAIT : rd_next = RD_RRDY_WAIT;   // Register block latency
         RD_RRDY_WAIT : if (rready) rd_next = RD_IDLE;
         default      : rd_next = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (arvalid_q && arready)
         arid_lat <= arid_q;
   end

   // Control pulses, registered from the next state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         arready <= 1'b0;
         reg_ren <= 1'b0;
         rvalid  <= 1'b0;
      end
      else
      begin
         arready <= (rd_next == RD_ADDR_RDY);
         reg_ren <= (rd_next == RD_REG_RD);
         rvalid  <= (rd_next == RD_RRDY_WAIT);
      end
   end

   always_ff @(posedge clk)
   begin
      // Host still holds araddr through the handshake edge
      if (rd_next == RD_REG_RD)
         reg_raddr <= araddr_q[`CSR_ADDR_W-1:0];
      // Register data is valid here and stays put while rvalid waits
      if (rd_state == RD_DATA_WAIT)
      begin
         rdata <= reg_rdata;
         rid   <= arid_lat;
      end
   end

endmodule

// File: logic/mailbox_regs.sv
`timescale 1ns/1ps
`include "csr_bridge_macros.svh"

module mailbox_regs (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      reg_wen,
   input  csr_bridge_pkg::csr_addr_t reg_waddr,
   input  csr_bridge_pkg::csr_data_t reg_wdata,
   input  csr_bridge_pkg::csr_strb_t reg_wstrb,
   input  logic                      reg_ren,
   input  csr_bridge_pkg::csr_addr_t reg_raddr,
   output csr_bridge_pkg::csr_data_t reg_rdata
);

   import csr_bridge_pkg::*;

   csr_data_t mbx_cmd;
   csr_data_t mbx_data;
   csr_data_t doorbell;
   logic      wr_cmd;
   logic      wr_data;

   // Only command and data are writable
   assign wr_cmd  = reg_wen && (reg_waddr == `CSR_MBX_CMD_ADDR);
   assign wr_data = reg_wen && (reg_waddr == `CSR_MBX_DATA_ADDR);

   // -------------------------------------------------------------------------
   // Mailbox registers and doorbell
   // -------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         mbx_cmd  <= '0;
         mbx_data <= '0;
         doorbell <= '0;
      end
      else
      begin
         for (int i = 0; i < `CSR_STRB_W; i++)
         begin
            if (wr_cmd && reg_wstrb[i])
               mbx_cmd[8*i +: 8] <= reg_wdata[8*i +: 8];
            if (wr_data && reg_wstrb[i])
               mbx_data[8*i +: 8] <= reg_wdata[8*i +: 8];
         end
         if (wr_cmd || wr_data)
            doorbell <= doorbell + 32'd1;   // Counts even with no strobes, wraps
      end
   end

   // Read mux, one cycle of latency
   always_ff @(posedge clk)
   begin
      if (reg_ren)
      begin
         case (reg_raddr)
            `CSR_MBX_CMD_ADDR  : reg_rdata <= mbx_cmd;
            `CSR_DOORBELL_ADDR : reg_rdata <= doorbell;
            `CSR_MBX_DATA_ADDR : reg_rdata <= mbx_data;
            // Above the window reads as all ones
            default            : reg_rdata <= (reg_raddr > `CSR_MBX_DATA_ADDR) ?
                                              {`CSR_DATA_W{1'b1}} : {`CSR_DATA_W{1'b0}};
         endcase
      end
   end

endmodule

// File: logic/csr_bridge_top.sv
`timescale 1ns/1ps

module csr_bridge_top (
   input  logic                      clk,
   input  logic                      rst_n,
   // Write address channel
   input  logic                      awvalid,
   input  csr_bridge_pkg::axi_addr_t awaddr,
   input  csr_bridge_pkg::axi_id_t   awid,
   output logic                      awready,
   // Write data channel
   input  logic                      wvalid,
   input  csr_bridge_pkg::csr_data_t wdata,
   input  csr_bridge_pkg::csr_strb_t wstrb,
   output logic                      wready,
   // Write response channel
   input  logic                      bready,
   output logic                      bvalid,
   output csr_bridge_pkg::axi_id_t   bid,
   // Read address channel
   input  logic                      arvalid,
   input  csr_bridge_pkg::axi_addr_t araddr,
   input  csr_bridge_pkg::axi_id_t   arid,
   output logic                      arready,
   // Read data channel
   input  logic                      rready,
   output logic                      rvalid,
   output csr_bridge_pkg::csr_data_t rdata,
   output csr_bridge_pkg::axi_id_t   rid
);

   import csr_bridge_pkg::*;

   // -------------------------------------------------------------------------
   // Register access between the engines and the mailbox
   // -------------------------------------------------------------------------

   logic      reg_wen;
   csr_addr_t reg_waddr;
   csr_data_t reg_wdata;
   csr_strb_t reg_wstrb;
   logic      reg_ren;
   csr_addr_t reg_raddr;
   csr_data_t reg_rdata;

   axi_write_slave i_wr (
      .clk       (clk),
      .rst_n     (rst_n),
      .awvalid   (awvalid),
      .awaddr    (awaddr),
      .awid      (awid),
      .awready   (awready),
      .wvalid    (wvalid),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wready    (wready),
      .bready    (bready),
      .bvalid    (bvalid),
      .bid       (bid),
      .reg_wen   (reg_wen),
      .reg_waddr (reg_waddr),
      .reg_wdata (reg_wdata),
      .reg_wstrb (reg_wstrb)
   );

   axi_read_slave i_rd (
      .clk       (clk),
      .rst_n     (rst_n),
      .arvalid   (arvalid),
      .araddr    (araddr),
      .arid      (arid),
      .arready   (arready),
      .rready    (rready),
      .rvalid    (rvalid),
      .rdata     (rdata),
      .rid       (rid),
      .reg_ren   (reg_ren),
      .reg_raddr (reg_raddr),
      .reg_rdata (reg_rdata)
   );

   // Both engines share the one register block
   mailbox_regs i_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .reg_wen   (reg_wen),
      .reg_waddr (reg_waddr),
      .reg_wdata (reg_wdata),
      .reg_wstrb (reg_wstrb),
      .reg_ren   (reg_ren),
      .reg_raddr (reg_raddr),
      .reg_rdata (reg_rdata)
   );

endmodule

// File: tests/csr_bridge_tb.sv
`timescale 1ns/1ps
`include "csr_bridge_macros.svh"

module csr_bridge_tb;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_TXN    = 201;   // Upper bound on host transactions
   localparam int TXN_CYCLES = 40;    // Worst case per transaction, ready delays included

   logic                       clk;
   logic                       rst_n;
   logic                       awvalid;
   logic [`CSR_AXI_ADDR_W-1:0] awaddr;
   logic [`CSR_ID_W-1:0]       awid;
   logic                       awready;
   logic                       wvalid;
   logic [`CSR_DATA_W-1:0]     wdata;
   logic [`CSR_STRB_W-1:0]     wstrb;
   logic                       wready;
   logic                       bready;
   logic                       bvalid;
   logic [`CSR_ID_W-1:0]       bid;
   logic                       arvalid;
   logic [`CSR_AXI_ADDR_W-1:0] araddr;
   logic [`CSR_ID_W-1:0]       arid;
   logic                       arready;
   logic                       rready;
   logic                       rvalid;
   logic [`CSR_DATA_W-1:0]     rdata;
   logic [`CSR_ID_W-1:0]       rid;

   // Model state
   logic [31:0] mdl_cmd;
   logic [31:0] mdl_data;
   logic [31:0] mdl_bell;

   logic [15:0] lfsr;
   int          fail_count;

   // Expected and observed pairs for the compare process
   logic [31:0] exp_q[$];
   logic [31:0] act_q[$];
   string       name_q[$];

   csr_bridge_top i_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Random source, reference model and checker
   // ------------------------------------------------------------------------

   // Galois LFSR, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         val  = {val[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return val;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
      logic [31:0] res;
      res = old_val;
      for (int i = 0; i < 4; i++)
         if (strb[i])
            res[8*i +: 8] = new_val[8*i +: 8];
      return res;
   endfunction

   // Read rule over the low 16 address bits
   function automatic logic [31:0] model_read(input logic [20:0] addr);
      logic [15:0] a;
      a = addr[15:0];
      if (a == 16'h0150)
         return mdl_cmd;
      else if (a == 16'h0154)
         return mdl_bell;
      else if (a == 16'h0158)
         return mdl_data;
      else if (a > 16'h0158)
         return 32'hFFFF_FFFF;
      return 32'h0;
   endfunction

   task automatic model_write(input logic [20:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
      logic [15:0] a;
      a = addr[15:0];
      if (a == 16'h0150)
      begin
         mdl_cmd  = merge_bytes(mdl_cmd, data, strb);
         mdl_bell = mdl_bell + 32'd1;
      end
      else if (a == 16'h0158)
      begin
         mdl_data = merge_bytes(mdl_data, data, strb);
         mdl_bell = mdl_bell + 32'd1;
      end
   endtask

   task automatic expect_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
      exp_q.push_back(exp_v);
      act_q.push_back(act_v);
      name_q.push_back(name);
   endtask

   task automatic check(input string name, input logic [31:0] exp_v,
                        input logic [31:0] act_v);
      if (exp_v !== act_v)
      begin
         fail_count++;
         $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   initial
   begin
      forever
      begin
         @(negedge clk);
         while (exp_q.size() != 0)
            check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
      end
   end

   initial
   begin
      #((NUM_TXN * TXN_CYCLES + 10) * CLK_PERIOD);
      $display("Watchdog expired, a handshake never completed");
      $display("TEST FAILED");
      $fatal(1);
   end

   // ------------------------------------------------------------------------
   // Host bus tasks
   // ------------------------------------------------------------------------

   task automatic axi_write(input logic [20:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [3:0] id,
                            input int bdelay);
      @(posedge clk);
      #1;
      awvalid = 1'b1;
      awaddr  = addr;
      awid    = id;
      wvalid  = 1'b1;
      wdata   = data;
      wstrb   = strb;
      do @(negedge clk); while (!awready);
      @(posedge clk);
      #1 awvalid = 1'b0;
      expect_val("awready", 32'd0, {31'd0, awready});   // One-cycle pulse
      do @(negedge clk); while (!wready);
      @(posedge clk);
      #1 wvalid = 1'b0;
      expect_val("wready", 32'd0, {31'd0, wready});
      do @(negedge clk); while (!bvalid);
      repeat (bdelay)
      begin
         @(negedge clk);
         expect_val("bvalid", 32'd1, {31'd0, bvalid});   // Held until bready
      end
      @(posedge clk);
      #1 bready = 1'b1;
      @(negedge clk);
      expect_val("bvalid", 32'd1, {31'd0, bvalid});
      expect_val("bid", {28'd0, id}, {28'd0, bid});
      @(posedge clk);
      #1 bready = 1'b0;
      model_write(addr, data, strb);
   endtask

   task automatic axi_read(input logic [20:0] addr, input logic [3:0] id,
                           input int rdelay);
      logic [31:0] exp_d;
      exp_d = model_read(addr);
      @(posedge clk);
      #1;
      arvalid = 1'b1;
      araddr  = addr;
      arid    = id;
      do @(negedge clk); while (!arready);
      @(posedge clk);
      #1 arvalid = 1'b0;
      expect_val("arready", 32'd0, {31'd0, arready});
      do @(negedge clk); while (!rvalid);
      repeat (rdelay)
      begin
         @(negedge clk);
         expect_val("rvalid", 32'd1, {31'd0, rvalid});
      end
      @(posedge clk);
      #1 rready = 1'b1;
      @(negedge clk);
      expect_val("rvalid", 32'd1, {31'd0, rvalid});
      expect_val("rdata", exp_d, rdata);
      expect_val("rid", {28'd0, id}, {28'd0, rid});
      @(posedge clk);
      #1 rready = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------

   initial
   begin
      logic [20:0] addr;
      logic [15:0] low;
      rst_n      = 1'b0;
      awvalid    = 1'b0;
      awaddr     = '0;
      awid       = '0;
      wvalid     = 1'b0;
      wdata      = '0;
      wstrb      = '0;
      bready     = 1'b0;
      arvalid    = 1'b0;
      araddr     = '0;
      arid       = '0;
      rready     = 1'b0;
      mdl_cmd    = '0;
      mdl_data   = '0;
      mdl_bell   = '0;
      lfsr       = 16'd21289;
      fail_count = 0;
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;

      // Reset values
      axi_read(21'h150, take_bits(4), 0);
      axi_read(21'h154, take_bits(4), 0);
      axi_read(21'h158, take_bits(4), 0);

      // Full strobe writes and readback
      for (int i = 0; i < 6; i++)
      begin
         axi_write(21'h150, take_bits(32), 4'hF, take_bits(4), 0);
         axi_read(21'h150, take_bits(4), 0);
         axi_write(21'h158, take_bits(32), 4'hF, take_bits(4), 0);
         axi_read(21'h158, take_bits(4), 0);
      end
      axi_read(21'h154, take_bits(4), 0);
      expect_val("doorbell count", 32'd12, rdata);

      // Partial strobes, upper host bits random
      for (int i = 0; i < 12; i++)
      begin
         low  = take_bits(1) ? 16'h0158 : 16'h0150;
         addr = {5'(take_bits(5)), low};
         axi_write(addr, take_bits(32), take_bits(4), take_bits(4), 0);
         axi_read(addr, take_bits(4), 0);
      end

      // Read-only doorbell and unmapped addresses
      for (int i = 0; i < 6; i++)
      begin
         axi_write(21'h154, take_bits(32), 4'hF, take_bits(4), 0);
         axi_write({5'd0, 16'h0100 + 16'(take_bits(6))}, take_bits(32), 4'hF,
                   take_bits(4), 0);
         axi_write({5'd0, 16'h0159 + 16'(take_bits(12))}, take_bits(32), 4'hF,
                   take_bits(4), 0);
         axi_read(21'h150, take_bits(4), 0);
         axi_read(21'h154, take_bits(4), 0);
         axi_read(21'h158, take_bits(4), 0);
         axi_read({5'(take_bits(5)), 16'h0159 + 16'(take_bits(15))}, take_bits(4), 0);
         axi_read({5'(take_bits(5)), 16'(take_bits(8)) + 16'h0050}, take_bits(4), 0);
      end
      axi_read(21'h152, take_bits(4), 0);

      // Random ready delays, read of one register while the other is written
      for (int i = 0; i < 20; i++)
      begin
         fork
            axi_write(21'h150, take_bits(32), take_bits(4), take_bits(4), take_bits(3));
            axi_read(21'h158, take_bits(4), take_bits(3));
         join
         fork
            axi_write(21'h158, take_bits(32), take_bits(4), take_bits(4), take_bits(3));
            axi_read(21'h150, take_bits(4), take_bits(3));
         join
         axi_read(21'h154, take_bits(4), take_bits(3));
      end

      while (exp_q.size() != 0)
         @(posedge clk);
      @(posedge clk);
      if (fail_count == 0)
      begin
         $display("TEST OK");
         $finish;
      end
      else
      begin
         $display("TEST FAILED");
         $fatal(1);
      end
   end

endmodule

// File: list.f
+incdir+logic
logic/csr_bridge_pkg.sv
logic/axi_write_slave.sv
logic/axi_read_slave.sv
logic/mailbox_regs.sv
logic/csr_bridge_top.sv
tests/csr_bridge_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= csr_bridge_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
